/* source/drumPkg.sv */
package drumPkg;

  // one quadrant of the symmetric drum.
  localparam int xSize = 5;
  localparam int ySize = 5;
  localparam int nodeCount = xSize * ySize;

  // far corner is the centre of the full drum.
  localparam int pickupIndex = nodeCount - 1;

  // signed fixed point with 17 fraction bits.
  localparam int sampleWidth = 18;
  localparam int fracBits = 17;

  // guard bits for the four-neighbour sum.
  localparam int lapWidth = sampleWidth + 3;
  // wide enough for any product before the shift.
  localparam int accWidth = 2 * sampleWidth + 4;

  typedef logic signed [sampleWidth-1:0] sampleT;
  typedef logic signed [lapWidth-1:0] lapT;
  typedef logic signed [accWidth-1:0] accT;

  // stability limit of 0.49 on the effective tension.
  localparam sampleT rhoMax = 18'sh0FAE1;

  // saturation bounds of the displacement.
  localparam sampleT sampleMax = {1'b0, {(sampleWidth - 1){1'b1}}};
  localparam sampleT sampleMin = {1'b1, {(sampleWidth - 1){1'b0}}};

  // membrane coefficients shared by every node.
  typedef struct packed {
    sampleT     rho;
    sampleT     eta;
    logic [2:0] tensionSel;
  } drumParamsT;

  // displacements seen by one node.
  typedef struct packed {
    sampleT north;
    sampleT south;
    sampleT east;
    sampleT west;
  } neighborsT;

  // row-major position of a node in the flat grid.
  function automatic int nodeIndex(int row, int col);
    return row * xSize + col;
  endfunction

endpackage

/* source/meshNode.sv */
`timescale 1ns/1ps

module meshNode import drumPkg::*; (
  input  logic       allValid,
  input  logic       arstN,
  input  logic       load,
  input  logic       step,
  input  sampleT     uInit,
  input  neighborsT  neighbors,
  input  drumParamsT params,
  output sampleT     u,
  output sampleT     uNext
);

  // displacement one step back.
  sampleT uPrev;

  lapT    lap;
  accT    uSquared;
  accT    tension;
  accT    rhoSum;
  sampleT rhoEff;
  accT    rhoTerm;
  accT    velocity;
  accT    dampTerm;
  accT    nextWide;

  // discrete laplacian, kept wide.
  assign lap = lapT'(neighbors.north) + lapT'(neighbors.south)
             + lapT'(neighbors.east) + lapT'(neighbors.west)
             - (lapT'(u) <<< 2);

  // u squared back in sample scale.
  assign uSquared = (accT'(u) * accT'(u)) >>> fracBits;

  // tension grows with displacement.
  always_comb begin
    if (params.tensionSel == 3'd0) begin
      tension = '0;
    end else begin
      tension = uSquared >>> (params.tensionSel - 3'd1);
    end
  end

  assign rhoSum = accT'(params.rho) + tension;

  // clamp keeps the scheme stable.
  assign rhoEff = (rhoSum > accT'(rhoMax)) ? rhoMax : sampleT'(rhoSum);

  // wave term.
  assign rhoTerm = (accT'(rhoEff) * accT'(lap)) >>> fracBits;

  // velocity damping.
  assign velocity = accT'(u) - accT'(uPrev);
  assign dampTerm = (accT'(params.eta) * velocity) >>> fracBits;

  assign nextWide = rhoTerm + (accT'(u) <<< 1) - accT'(uPrev) - dampTerm;

  // saturate to the sample range.
  always_comb begin
    if (nextWide > accT'(sampleMax)) begin
      uNext = sampleMax;
    end else if (nextWide < accT'(sampleMin)) begin
      uNext = sampleMin;
    end else begin
      uNext = sampleT'(nextWide);
    end
  end

  // load has priority over step.
  always_ff @(posedge allValid or negedge arstN) begin
    if (!arstN) begin
      u     <= '0;
      uPrev <= '0;
    end else if (load) begin
      u     <= uInit;
      uPrev <= uInit;
    end else if (step) begin
      uPrev <= u;
      u     <= uNext;
    end
  end

endmodule

/* source/pluckShape.sv */
`timescale 1ns/1ps

module pluckShape import drumPkg::*; (
  input  sampleT                   amplitude,
  output sampleT [nodeCount-1:0]   shape
);

  // quadrant gaussian, symmetric about the diagonal.
  function automatic sampleT shapeEntry(int row, int col);
    int     lo;
    int     hi;
    sampleT entry;
    lo = (row < col) ? row : col;
    hi = (row < col) ? col : row;
    entry = '0;
    case (lo)
      1: begin
        case (hi)
          1: entry = 18'sh0043B;
          2: entry = 18'sh006FA;
          3: entry = 18'sh0096B;
          4: entry = 18'sh00A68;
          default: entry = '0;
        endcase
      end
      2: begin
        case (hi)
          2: entry = 18'sh00B81;
          3: entry = 18'sh00F87;
          4: entry = 18'sh01129;
          default: entry = '0;
        endcase
      end
      3: entry = (hi == 3) ? 18'sh014F6 : 18'sh0172A;
      4: entry = 18'sh0199A;
      // clamped row and column stay flat.
      default: entry = '0;
    endcase
    return entry;
  endfunction

  for (genvar row = 0; row < ySize; row++) begin : rowGen
    for (genvar col = 0; col < xSize; col++) begin : colGen
      accT product;

      assign product = accT'(shapeEntry(row, col)) * accT'(amplitude);
      assign shape[nodeIndex(row, col)] = sampleT'(product >>> fracBits);
    end
  end

endmodule

/* source/nodeMesh.sv */
`timescale 1ns/1ps

module nodeMesh import drumPkg::*; (
  input  logic                   allValid,
  input  logic                   arstN,
  input  logic                   load,
  input  logic                   step,
  input  sampleT [nodeCount-1:0] initShape,
  input  drumParamsT             params,
  output sampleT                 pickup,
  output sampleT                 pickupNext
);

  // current and next displacement of every node.
  sampleT meshU    [nodeCount];
  sampleT meshNext [nodeCount];

  for (genvar row = 0; row < ySize; row++) begin : rowGen
    for (genvar col = 0; col < xSize; col++) begin : colGen
      sampleT    north;
      sampleT    south;
      sampleT    east;
      sampleT    west;
      neighborsT nbrs;

      // rim of the drum is clamped.
      if (row == 0) begin : northClamp
        assign north = '0;
      end else begin : northLink
        assign north = meshU[nodeIndex(row - 1, col)];
      end

      if (col == 0) begin : westClamp
        assign west = '0;
      end else begin : westLink
        assign west = meshU[nodeIndex(row, col - 1)];
      end

      // symmetry axes mirror the node itself.
      if (row == ySize - 1) begin : southMirror
        assign south = meshU[nodeIndex(row, col)];
      end else begin : southLink
        assign south = meshU[nodeIndex(row + 1, col)];
      end

      if (col == xSize - 1) begin : eastMirror
        assign east = meshU[nodeIndex(row, col)];
      end else begin : eastLink
        assign east = meshU[nodeIndex(row, col + 1)];
      end

      assign nbrs = '{north: north, south: south, east: east, west: west};

      meshNode node_i (
        .allValid  (allValid),
        .arstN     (arstN),
        .load      (load),
        .step      (step),
        .uInit     (initShape[nodeIndex(row, col)]),
        .neighbors (nbrs),
        .params    (params),
        .u         (meshU[nodeIndex(row, col)]),
        .uNext     (meshNext[nodeIndex(row, col)])
      );
    end
  end

  // centre of the full drum.
  assign pickup     = meshU[pickupIndex];
  assign pickupNext = meshNext[pickupIndex];

endmodule

/* source/drumSynth.sv */
`timescale 1ns/1ps

module drumSynth import drumPkg::*; (
  input  logic       allValid,
  input  logic       arstN,
  input  logic       strike,
  input  sampleT     amplitude,
  input  drumParamsT params,
  input  logic       run,
  output sampleT     sample,
  output logic       sampleValid
);

  sampleT [nodeCount-1:0] initShape;
  sampleT                 pickupNext;
  logic                   load;
  logic                   step;

  // strike wins over run.
  assign load = strike;
  assign step = run & ~strike;

  pluckShape shape_i (
    .amplitude (amplitude),
    .shape     (initShape)
  );

  nodeMesh mesh_i (
    .allValid   (allValid),
    .arstN      (arstN),
    .load       (load),
    .step       (step),
    .initShape  (initShape),
    .params     (params),
    .pickup     (),
    .pickupNext (pickupNext)
  );

  // sample tracks the pickup's new value on each step.
  always_ff @(posedge allValid or negedge arstN) begin
    if (!arstN) begin
      sample      <= '0;
      sampleValid <= 1'b0;
    end else begin
      sampleValid <= step;
      if (step) begin
        sample <= pickupNext;
      end
    end
  end

endmodule

/* dv/drumSynth_assert.sv */
`timescale 1ns/1ps

module drumSynthAssert import drumPkg::*; (
  input logic   allValid,
  input logic   arstN,
  input logic   strike,
  input logic   run,
  input sampleT sample,
  input logic   sampleValid
);

  // a sample only follows an edge that stepped the mesh.
  validAfterStep: assert property (
    @(posedge allValid) disable iff (!arstN)
    sampleValid |-> $past(run && !strike)
  ) else $error("sampleValid was high without a step on the previous edge");

  // no output strobe while reset holds.
  idleInReset: assert property (
    @(posedge allValid)
    !arstN |=> !sampleValid
  ) else $error("sampleValid was high during reset");

  // outputs stay defined once out of reset.
  outputsKnown: assert property (
    @(posedge allValid) disable iff (!arstN)
    !$isunknown(sample) && !$isunknown(sampleValid)
  ) else $error("sample or sampleValid is unknown after reset");

endmodule

/* dv/drumChecker.sv */
`timescale 1ns/1ps

module drumChecker import drumPkg::*; (
  input  logic       allValid,
  input  logic       arstN,
  input  logic       strike,
  input  sampleT     amplitude,
  input  drumParamsT params,
  input  logic       run,
  input  sampleT     sample,
  input  logic       sampleValid,
  output int         errorCount
);

  // bell-shaped quadrant pluck, flat on the clamped rim.
  localparam int shapeTable [ySize][xSize] = '{
    '{0, 0,      0,      0,      0},
    '{0, 'h043B, 'h06FA, 'h096B, 'h0A68},
    '{0, 'h06FA, 'h0B81, 'h0F87, 'h1129},
    '{0, 'h096B, 'h0F87, 'h14F6, 'h172A},
    '{0, 'h0A68, 'h1129, 'h172A, 'h199A}
  };

  longint modelU    [ySize][xSize];
  longint modelPrev [ySize][xSize];
  sampleT expSample;
  logic   expValid;

  function automatic longint saturate(input longint value);
    if (value > longint'(sampleMax)) begin
      return longint'(sampleMax);
    end
    if (value < longint'(sampleMin)) begin
      return longint'(sampleMin);
    end
    return value;
  endfunction

  task automatic clearModel();
    for (int row = 0; row < ySize; row++) begin
      for (int col = 0; col < xSize; col++) begin
        modelU[row][col]    = 0;
        modelPrev[row][col] = 0;
      end
    end
  endtask

  // strike puts the scaled shape in both time levels.
  task automatic loadModel();
    longint scaled;
    for (int row = 0; row < ySize; row++) begin
      for (int col = 0; col < xSize; col++) begin
        scaled = (longint'(shapeTable[row][col]) * longint'(amplitude)) >>> fracBits;
        modelU[row][col]    = scaled;
        modelPrev[row][col] = scaled;
      end
    end
  endtask

  task automatic stepModel();
    longint nextU [ySize][xSize];
    longint north;
    longint south;
    longint east;
    longint west;
    longint lap;
    longint uSq;
    longint tension;
    longint rhoEff;
    longint damp;
    for (int row = 0; row < ySize; row++) begin
      for (int col = 0; col < xSize; col++) begin
        // clamped north and west, mirrored south and east.
        north = (row == 0) ? 0 : modelU[row - 1][col];
        west  = (col == 0) ? 0 : modelU[row][col - 1];
        south = (row == ySize - 1) ? modelU[row][col] : modelU[row + 1][col];
        east  = (col == xSize - 1) ? modelU[row][col] : modelU[row][col + 1];
        lap = north + south + east + west - 4 * modelU[row][col];
        uSq = (modelU[row][col] * modelU[row][col]) >>> fracBits;
        tension = (params.tensionSel == 3'd0) ? 0 : uSq >>> (params.tensionSel - 3'd1);
        rhoEff = longint'(params.rho) + tension;
        if (rhoEff > longint'(rhoMax)) begin
          rhoEff = longint'(rhoMax);
        end
        damp = (longint'(params.eta) * (modelU[row][col] - modelPrev[row][col])) >>> fracBits;
        nextU[row][col] = saturate(((rhoEff * lap) >>> fracBits) + 2 * modelU[row][col]
                                   - modelPrev[row][col] - damp);
      end
    end
    modelPrev = modelU;
    modelU    = nextU;
  endtask

  // outputs seen at an edge belong to the previous edge.
  always @(posedge allValid or negedge arstN) begin
    if (!arstN) begin
      clearModel();
      expSample  = '0;
      expValid   = 1'b0;
      errorCount = 0;
    end else begin
      if (sampleValid !== expValid) begin
        $display("Fail sampleValid: got %h expected %h", sampleValid, expValid);
        errorCount++;
      end
      if (sample !== expSample) begin
        $display("Fail sample: got %05h expected %05h", sample, expSample);
        errorCount++;
      end
      if (strike) begin
        loadModel();
        expValid = 1'b0;
      end else if (run) begin
        stepModel();
        expSample = sampleT'(modelU[ySize - 1][xSize - 1]);
        expValid  = 1'b1;
      end else begin
        expValid = 1'b0;
      end
    end
  end

endmodule

/* dv/drumSynthTb.sv */
`timescale 1ns/1ps

module drumSynthTb import drumPkg::*; ();

  // cycles allowed between two samples while running.
  localparam int stepTimeout = 20;

  logic       allValid;
  logic       arstN;
  logic       strike;
  sampleT     amplitude;
  drumParamsT params;
  logic       run;
  sampleT     sample;
  logic       sampleValid;

  int     seed = 32'he0bc_9951;
  int     checkErrors;
  int     localErrors;
  int     testCount;
  int     failedTests;
  int     testStart;
  sampleT captured [$];

  drumSynth dut_i (
    .allValid    (allValid),
    .arstN       (arstN),
    .strike      (strike),
    .amplitude   (amplitude),
    .params      (params),
    .run         (run),
    .sample      (sample),
    .sampleValid (sampleValid)
  );

  drumChecker checker_i (
    .allValid    (allValid),
    .arstN       (arstN),
    .strike      (strike),
    .amplitude   (amplitude),
    .params      (params),
    .run         (run),
    .sample      (sample),
    .sampleValid (sampleValid),
    .errorCount  (checkErrors)
  );

  bind drumSynth drumSynthAssert assert_i (
    .allValid    (allValid),
    .arstN       (arstN),
    .strike      (strike),
    .run         (run),
    .sample      (sample),
    .sampleValid (sampleValid)
  );

  initial begin
    allValid = 1'b0;
    forever #50 allValid = ~allValid;
  end

  function automatic int randBelow(input int limit);
    int value;
    value = $random(seed);
    return (value & 32'h7fff_ffff) % limit;
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge allValid);
      run    <= 1'b0;
      strike <= 1'b0;
    end
  endtask

  task automatic setParams(input sampleT rho, input sampleT eta, input logic [2:0] sel);
    @(posedge allValid);
    params <= '{rho: rho, eta: eta, tensionSel: sel};
  endtask

  task automatic strikeMesh(input sampleT amp, input logic runHigh);
    @(posedge allValid);
    strike    <= 1'b1;
    amplitude <= amp;
    run       <= runHigh;
    @(posedge allValid);
    strike <= 1'b0;
  endtask

  // runs until count samples arrived, keeping them in captured.
  task automatic runSteps(input int count);
    int got;
    int waited;
    captured.delete();
    got = 0;
    @(posedge allValid);
    run <= 1'b1;
    while (got < count) begin
      waited = 0;
      do begin
        @(negedge allValid);
        waited++;
      end while (!sampleValid && waited < stepTimeout);
      if (!sampleValid) begin
        $display("sampleValid never came within %0d cycles of run", stepTimeout);
        localErrors++;
        break;
      end
      captured.push_back(sample);
      got++;
    end
    @(posedge allValid);
    run <= 1'b0;
  endtask

  function automatic logic changesSign();
    logic seenPos;
    logic seenNeg;
    seenPos = 1'b0;
    seenNeg = 1'b0;
    foreach (captured[i]) begin
      if (captured[i] > 0) seenPos = 1'b1;
      if (captured[i] < 0) seenNeg = 1'b1;
    end
    return seenPos && seenNeg;
  endfunction

  function automatic int peakOf(input int first, input int count);
    int peak;
    int value;
    peak = 0;
    for (int i = first; i < first + count; i++) begin
      value = int'(captured[i]);
      if (value < 0) value = -value;
      if (value > peak) peak = value;
    end
    return peak;
  endfunction

  task automatic beginTest();
    testStart = checkErrors + localErrors;
  endtask

  task automatic endTest(input string name);
    int errs;
    idle(2);
    errs = checkErrors + localErrors - testStart;
    testCount++;
    if (errs != 0) failedTests++;
    $display("test %0d %s: %0d errors", testCount, name, errs);
  endtask

  initial begin
    arstN       = 1'b0;
    strike      = 1'b0;
    amplitude   = '0;
    params      = '0;
    run         = 1'b0;
    localErrors = 0;
    testCount   = 0;
    failedTests = 0;
    repeat (5) @(posedge allValid);
    arstN <= 1'b1;

    beginTest();
    idle(10 + randBelow(30));
    endTest("reset idle");

    beginTest();
    setParams(sampleT'(randBelow(int'(rhoMax))), '0, 3'd0);
    strikeMesh(sampleT'($random(seed)), 1'b0);
    runSteps(24);
    endTest("strike and first step");

    // lossless mesh should ring through zero.
    beginTest();
    setParams(sampleT'('h4000 + randBelow('hBAE1)), '0, 3'd0);
    strikeMesh(sampleT'('h10000 + randBelow('h8000)), 1'b0);
    runSteps(160);
    if (!changesSign()) begin
      $display("lossless ringing never changed sign");
      localErrors++;
    end
    endTest("lossless ringing");

    beginTest();
    setParams(sampleT'('h8000 + randBelow('h7000)), sampleT'('h2000 + randBelow('h2000)), 3'd0);
    strikeMesh(sampleT'('h10000 + randBelow('h8000)), 1'b0);
    runSteps(256);
    if (captured.size() >= 64) begin
      if (peakOf(captured.size() - 32, 32) >= peakOf(0, 32)) begin
        $display("damped output did not decay over the run");
        localErrors++;
      end
    end
    endTest("damping");

    beginTest();
    repeat (3) begin
      setParams(sampleT'(int'(rhoMax) - randBelow('h800)), sampleT'(randBelow('h400)),
                3'(1 + randBelow(7)));
      strikeMesh(sampleT'('h1C000 + randBelow('h3FFF)), 1'b0);
      runSteps(64);
    end
    endTest("tension and saturation");

    // gaps in run, then a strike while running.
    beginTest();
    setParams(sampleT'('h4000 + randBelow('hB000)), sampleT'(randBelow('h800)), 3'd0);
    strikeMesh(sampleT'('h8000 + randBelow('h10000)), 1'b0);
    repeat (6) begin
      runSteps(1 + randBelow(8));
      idle(1 + randBelow(6));
    end
    strikeMesh(sampleT'('h8000 + randBelow('h10000)), 1'b1);
    runSteps(16);
    endTest("pause and re-strike");

    $display("tests %0d, failed %0d, errors %0d", testCount, failedTests,
             checkErrors + localErrors);
    if (checkErrors + localErrors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* drumMesh.f */
source/drumPkg.sv
source/meshNode.sv
source/pluckShape.sv
source/nodeMesh.sv
source/drumSynth.sv
dv/drumSynth_assert.sv
dv/drumChecker.sv
dv/drumSynthTb.sv

/* Makefile */
TOP = drumSynthTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f drumMesh.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f drumMesh.f --top-module $(TOP) \
		--Mdir obj_dir -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
